// File: compile.f
+incdir+testbench
design/chessPkg.sv
design/pieceQueryIf.sv
design/boardBuilder.sv
design/slideCounter.sv
design/stepMasker.sv
design/moveSequencer.sv
design/moveGenTop.sv
testbench/moveGenTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the move generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module moveGenTb -Mdir obj_dir -o moveGenSim \
    && ./obj_dir/moveGenSim | tee /dev/stderr | grep -qx "Test passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/moveGenRef.svh
`default_nettype none

// Expected move summary, built straight from the board rules

function automatic chessPkg::boardT refBoard(
    input logic [95:0] locW,
    input logic [95:0] locB,
    input logic [15:0] aliveW,
    input logic [15:0] aliveB
);
    chessPkg::boardT b;

    b = '0;
    for (int i = 0; i < 16; i++) begin
        if (aliveB[i]) begin
            b[locB[i*6+3 +: 3]][locB[i*6 +: 3]] = 2'b10;
        end
    end
    // White placed last and kept on a shared square
    for (int i = 0; i < 16; i++) begin
        if (aliveW[i]) begin
            b[locW[i*6+3 +: 3]][locW[i*6 +: 3]] = 2'b11;
        end
    end
    return b;
endfunction

function automatic logic [2:0] refRay(
    input chessPkg::boardT b,
    input int r,
    input int f,
    input int dr,
    input int df,
    input logic own
);
    int n;
    int rr;
    int ff;

    n = 0;
    rr = r + dr;
    ff = f + df;
    while (rr >= 0 && rr < 8 && ff >= 0 && ff < 8) begin
        if (b[rr][ff].occupied) begin
            if (b[rr][ff].white != own) n++;   // Capture square counts
            break;
        end
        n++;
        rr += dr;
        ff += df;
    end
    return n[2:0];
endfunction

function automatic logic refStep(
    input chessPkg::boardT b,
    input int r,
    input int f,
    input int dr,
    input int df,
    input logic own
);
    int rr;
    int ff;

    rr = r + dr;
    ff = f + df;
    if (rr < 0 || rr > 7 || ff < 0 || ff > 7) return 1'b0;
    return !b[rr][ff].occupied || (b[rr][ff].white != own);
endfunction

function automatic logic [95:0] moveGenRef(
    input logic        player,
    input logic [95:0] locW,
    input logic [95:0] locB,
    input logic [15:0] aliveW,
    input logic [15:0] aliveB
);
    chessPkg::boardT b;
    logic [95:0]     loc;
    logic [15:0]     alive;
    logic [95:0]     res;
    logic [11:0]     orth;
    logic [11:0]     diag;
    int              r;
    int              f;

    b = refBoard(locW, locB, aliveW, aliveB);
    loc = player ? locW : locB;
    alive = player ? aliveW : aliveB;
    res = '0;
    for (int idx = 0; idx < 8; idx++) begin
        r = int'(loc[idx*6+3 +: 3]);
        f = int'(loc[idx*6 +: 3]);
        orth = {refRay(b, r, f, 0, -1, player), refRay(b, r, f, 0, 1, player),
                refRay(b, r, f, 1, 0, player), refRay(b, r, f, -1, 0, player)};
        diag = {refRay(b, r, f, 1, -1, player), refRay(b, r, f, 1, 1, player),
                refRay(b, r, f, -1, -1, player), refRay(b, r, f, -1, 1, player)};
        if (alive[idx]) begin
            case (idx)
                7: res[95:84] = orth;
                6: res[83:72] = orth;
                5, 4: res[56 + 8*(idx-4) +: 8] = {
                    refStep(b, r, f, 2, -1, player), refStep(b, r, f, 1, -2, player),
                    refStep(b, r, f, 2, 1, player), refStep(b, r, f, 1, 2, player),
                    refStep(b, r, f, -2, -1, player), refStep(b, r, f, -1, -2, player),
                    refStep(b, r, f, -2, 1, player), refStep(b, r, f, -1, 2, player)};
                3: res[55:44] = diag;
                2: res[43:32] = diag;
                1: res[31:8] = {orth, diag};
                default: res[7:0] = {
                    refStep(b, r, f, 1, -1, player), refStep(b, r, f, 1, 0, player),
                    refStep(b, r, f, 1, 1, player), refStep(b, r, f, 0, 1, player),
                    refStep(b, r, f, -1, 1, player), refStep(b, r, f, -1, 0, player),
                    refStep(b, r, f, -1, -1, player), refStep(b, r, f, 0, -1, player)};
            endcase
        end
    end
    return res;
endfunction

`default_nettype wire

// File: testbench/moveGenTb.sv
`include "moveGenRef.svh"
`default_nettype none

module moveGenTb;
    import chessPkg::*;

    localparam int randomTests = 200;
    localparam int stallTests  = 20;
    localparam int testTotal   = 2 + randomTests + 1 + stallTests + 1;
    // Nine enabled edges at a worst en duty near one in four, plus overhead
    localparam int cycleBudget = testTotal * (9 * 4 + 12) + 200;

    logic        clk;
    logic        rstN;
    logic        en;
    logic        start;
    logic        player;
    logic [95:0] locationWhite;
    logic [95:0] locationBlack;
    logic [15:0] aliveWhite;
    logic [15:0] aliveBlack;
    logic [moveSetBits-1:0] moveSet;
    logic        done;

    int seed = 32'h6f2a7494;
    int testCount = 0;
    int failedTests = 0;
    int checkErrors = 0;
    int enabledEdges = 0;
    int doneCycles = 0;

    moveGenTop dut (
        .clk           (clk),
        .rstN          (rstN),
        .en            (en),
        .start         (start),
        .player        (player),
        .locationWhite (locationWhite),
        .locationBlack (locationBlack),
        .aliveWhite    (aliveWhite),
        .aliveBlack    (aliveBlack),
        .moveSet       (moveSet),
        .done          (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Edge bookkeeping, values seen here are the ones the DUT samples
    always @(posedge clk) begin
        if (rstN && en) begin
            enabledEdges++;
            if (done) doneCycles++;
        end
    end

    initial begin
        #(cycleBudget * 4);
        $display("Watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

    task automatic checkMoveSet(input string name, input logic [moveSetBits-1:0] got,
                                input logic [moveSetBits-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            checkErrors++;
        end
    endtask

    task automatic checkSquare(input int r, input int f, input squareT got, input squareT exp);
        if (got !== exp) begin
            $display("CHECK FAILED board[%0d][%0d]: got %h expected %h", r, f, got, exp);
            checkErrors++;
        end
    endtask

    task automatic checkDone(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            checkErrors++;
        end
    endtask

    function automatic logic [95:0] openingLoc(input logic [2:0] back, input logic [2:0] pawns);
        logic [95:0] v;
        logic [2:0]  files [8];

        files = '{3'd4, 3'd3, 3'd2, 3'd5, 3'd1, 3'd6, 3'd0, 3'd7};   // K Q B B N N R R
        for (int i = 0; i < 8; i++) begin
            v[i*6 +: 6] = {back, files[i]};
            v[(i+8)*6 +: 6] = {pawns, 3'(i)};
        end
        return v;
    endfunction

    task automatic randomPlacement(output logic [95:0] lw, output logic [95:0] lb,
                                   output logic [15:0] aw, output logic [15:0] ab);
        logic [63:0] used;
        logic [31:0] rnd;

        used = '0;
        for (int i = 0; i < 32; i++) begin
            do begin
                rnd = $random(seed);
            end while (used[rnd[5:0]]);
            used[rnd[5:0]] = 1'b1;
            if (i < 16) lw[i*6 +: 6] = rnd[5:0];
            else lb[(i-16)*6 +: 6] = rnd[5:0];
        end
        rnd = $random(seed);
        aw = rnd[15:0];
        ab = rnd[31:16];
    endtask

    // Mode 0 plain, 1 en stalls during the scan, 2 extra start mid-scan
    task automatic runTest(input string name, input int mode, input logic p,
                           input logic [95:0] lw, input logic [95:0] lb,
                           input logic [15:0] aw, input logic [15:0] ab);
        logic [95:0] expected;
        boardT       expBoard;
        logic [31:0] rnd;
        int          errorsBefore;
        int          acceptMark;
        int          pulseMark;
        int          k;

        errorsBefore = checkErrors;
        expected = moveGenRef(p, lw, lb, aw, ab);
        expBoard = refBoard(lw, lb, aw, ab);
        @(posedge clk);
        player <= p;
        locationWhite <= lw;
        locationBlack <= lb;
        aliveWhite <= aw;
        aliveBlack <= ab;
        en <= 1'b1;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        acceptMark = enabledEdges;
        pulseMark = doneCycles;
        k = 0;
        while (!done) begin
            @(posedge clk);
            k++;
            rnd = $random(seed);
            if (mode == 1) en <= rnd[0];
            if (mode == 2 && k == 3) begin
                start <= 1'b1;
                player <= ~p;
                locationWhite <= lb;
                locationBlack <= lw;
                aliveWhite <= ~aw;
            end
            if (mode == 2 && k == 4) start <= 1'b0;
            @(negedge clk);
        end
        checkDone("done latency after accept", enabledEdges - acceptMark, 8);
        checkMoveSet("moveSet", moveSet, expected);
        for (int r = 0; r < 8; r++) begin
            for (int f = 0; f < 8; f++) begin
                checkSquare(r, f, dut.uBoard.board[r][f], expBoard[r][f]);
            end
        end
        @(posedge clk);
        en <= 1'b1;
        do @(negedge clk); while (done);
        repeat (3) @(negedge clk);
        checkDone("done pulse count", doneCycles - pulseMark, 1);
        testCount++;
        if (checkErrors != errorsBefore) begin
            failedTests++;
            $display("%s: FAILED", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    initial begin
        logic [95:0] lw;
        logic [95:0] lb;
        logic [15:0] aw;
        logic [15:0] ab;
        logic [31:0] rnd;
        int          errorsBefore;

        rstN = 1'b0;
        en = 1'b0;
        start = 1'b0;
        player = 1'b0;
        locationWhite = '0;
        locationBlack = '0;
        aliveWhite = '0;
        aliveBlack = '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        en <= 1'b1;

        @(negedge clk);
        errorsBefore = checkErrors;
        checkMoveSet("moveSet after reset", moveSet, '0);
        checkDone("done after reset", int'(done), 0);
        testCount++;
        if (checkErrors != errorsBefore) failedTests++;
        $display("reset state: %s", (checkErrors != errorsBefore) ? "FAILED" : "ok");

        lw = openingLoc(3'd0, 3'd1);
        lb = openingLoc(3'd7, 3'd6);
        runTest("opening white", 0, 1'b1, lw, lb, 16'hffff, 16'hffff);
        runTest("opening black", 0, 1'b0, lw, lb, 16'hffff, 16'hffff);

        for (int i = 0; i < randomTests; i++) begin
            randomPlacement(lw, lb, aw, ab);
            rnd = $random(seed);
            runTest($sformatf("random %0d", i), 0, rnd[0], lw, lb, aw, ab);
        end

        randomPlacement(lw, lb, aw, ab);
        runTest("mover all dead", 0, 1'b1, lw, lb, 16'h0000, ab);
        checkMoveSet("moveSet with dead mover", moveSet, '0);

        for (int i = 0; i < stallTests; i++) begin
            randomPlacement(lw, lb, aw, ab);
            rnd = $random(seed);
            runTest($sformatf("en stall %0d", i), 1, rnd[0], lw, lb, aw, ab);
        end

        randomPlacement(lw, lb, aw, ab);
        runTest("start during scan", 2, 1'b1, lw, lb, aw, ab);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 testCount, failedTests, checkErrors);
        if (checkErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/moveGenTop.sv
`default_nettype none

module moveGenTop (
    input  wire logic                                              clk,
    input  wire logic                                              rstN,
    input  wire logic                                              en,
    input  wire logic                                              start,
    input  wire logic                                              player,  // 1 is white
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationWhite,
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationBlack,
    input  wire logic [chessPkg::pieceCount-1:0]                   aliveWhite,
    input  wire logic [chessPkg::pieceCount-1:0]                   aliveBlack,
    output logic [chessPkg::moveSetBits-1:0]                       moveSet,
    output logic                                                   done
);
    import chessPkg::*;

    boardT board;
    logic  load;

    pieceQueryIf query ();

    boardBuilder uBoard (
        .clk           (clk),
        .rstN          (rstN),
        .en            (en),
        .load          (load),
        .locationWhite (locationWhite),
        .locationBlack (locationBlack),
        .aliveWhite    (aliveWhite),
        .aliveBlack    (aliveBlack),
        .board         (board)
    );

    // Both evaluators answer within the query cycle
    slideCounter uSlide (
        .board (board),
        .query (query.slider)
    );

    stepMasker uStep (
        .board (board),
        .query (query.stepper)
    );

    moveSequencer uSeq (
        .clk           (clk),
        .rstN          (rstN),
        .en            (en),
        .start         (start),
        .player        (player),
        .locationWhite (locationWhite),
        .locationBlack (locationBlack),
        .aliveWhite    (aliveWhite),
        .aliveBlack    (aliveBlack),
        .load          (load),
        .query         (query.requester),
        .moveSet       (moveSet),
        .done          (done)
    );

endmodule

`default_nettype wire

// File: design/moveSequencer.sv
`default_nettype none

module moveSequencer (
    input  wire logic                                              clk,
    input  wire logic                                              rstN,
    input  wire logic                                              en,
    input  wire logic                                              start,
    input  wire logic                                              player,
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationWhite,
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationBlack,
    input  wire logic [chessPkg::pieceCount-1:0]                   aliveWhite,
    input  wire logic [chessPkg::pieceCount-1:0]                   aliveBlack,
    output logic                                                   load,
    pieceQueryIf.requester                                         query,
    output logic [chessPkg::moveSetBits-1:0]                       moveSet,
    output logic                                                   done
);
    import chessPkg::*;

    seqStateE                       state;
    logic [$clog2(scanCount)-1:0]   scanIdx;
    logic                           ownWhite;
    logic [pieceCount*locBits-1:0]  ownLoc;
    logic [pieceCount-1:0]          ownAlive;
    pieceKindE                      curKind;
    logic [queenField-1:0]          fieldVal;
    logic [moveSetBits-1:0]         placed;

    assign load = start && (state == idle);     // Accept when idle

    // Mover's side, captured at accept
    always_ff @(posedge clk) begin
        if (en && load) begin
            ownWhite <= player;
            ownLoc   <= player ? locationWhite : locationBlack;
            ownAlive <= player ? aliveWhite : aliveBlack;
        end
    end

    assign curKind        = pieceKindOf[scanIdx];
    assign query.kind     = curKind;
    assign query.ownWhite = ownWhite;
    assign query.rank     = entryRank(ownLoc, firstPiece + int'(scanIdx));
    assign query.file     = entryFile(ownLoc, firstPiece + int'(scanIdx));

    // Pick the part of the evaluator results this piece needs
    always_comb begin
        fieldVal = '0;
        if (ownAlive[firstPiece + int'(scanIdx)]) begin
            case (curKind)
                rook:    fieldVal = queenField'(query.rays[dirCount-1 -: 4]);  // Orthogonal
                bishop:  fieldVal = queenField'(query.rays[3:0]);              // Diagonal
                queen:   fieldVal = query.rays;
                default: fieldVal = queenField'(query.stepMask);
            endcase
        end
    end

    assign placed = moveSetBits'(fieldVal) << fieldLsb[scanIdx];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= idle;
            scanIdx <= '0;
            moveSet <= '0;
            done    <= 1'b0;
        end else if (en) begin
            done <= 1'b0;   // Single enabled cycle
            case (state)
                idle: begin
                    if (start) begin
                        state   <= scan;
                        scanIdx <= '1;      // Rook 7 first
                        moveSet <= '0;
                    end
                end
                scan: begin
                    // Fields were cleared at accept, so OR places each one
                    moveSet <= moveSet | placed;
                    if (scanIdx == '0) begin
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        scanIdx <= scanIdx - 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/stepMasker.sv
`default_nettype none

module stepMasker (
    input  wire chessPkg::boardT board,
    pieceQueryIf.stepper         query
);
    import chessPkg::*;

    always_comb begin
        int   r;
        int   f;
        int   dRank;
        int   dFile;
        logic stepper;

        query.stepMask = '0;
        stepper = (query.kind == knight) || (query.kind == king);
        for (int t = 0; t < dirCount; t++) begin
            if (query.kind == knight) begin
                dRank = knightRankStep[t];
                dFile = knightFileStep[t];
            end else begin
                dRank = kingRankStep[t];
                dFile = kingFileStep[t];
            end
            r = int'(query.rank) + dRank;
            f = int'(query.file) + dFile;
            if (stepper && r >= 0 && r < boardSize && f >= 0 && f < boardSize) begin
                // Empty target or an enemy piece
                if (!board[r[coordBits-1:0]][f[coordBits-1:0]].occupied
                        || board[r[coordBits-1:0]][f[coordBits-1:0]].white
                           != query.ownWhite) begin
                    query.stepMask[dirCount-1-t] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/slideCounter.sv
`default_nettype none

module slideCounter (
    input  wire chessPkg::boardT board,
    pieceQueryIf.slider          query
);
    import chessPkg::*;

    // One walk per direction, stopping at the edge or the first piece
    always_comb begin
        int                 r;
        int                 f;
        logic               blocked;
        logic [rayBits-1:0] count;

        query.rays = '0;
        for (int d = 0; d < dirCount; d++) begin
            blocked = 1'b0;
            count   = '0;
            for (int step = 1; step < boardSize; step++) begin
                r = int'(query.rank) + step * rayRankStep[d];
                f = int'(query.file) + step * rayFileStep[d];
                if (!blocked) begin
                    if (r < 0 || r >= boardSize || f < 0 || f >= boardSize) begin
                        blocked = 1'b1;     // Off the board
                    end else if (board[r[coordBits-1:0]][f[coordBits-1:0]].occupied) begin
                        // Opponent square is a capture and still counts
                        if (board[r[coordBits-1:0]][f[coordBits-1:0]].white
                                != query.ownWhite) begin
                            count = count + 1'b1;
                        end
                        blocked = 1'b1;
                    end else begin
                        count = count + 1'b1;
                    end
                end
            end
            query.rays[dirCount-1-d] = count;   // Left lands on top
        end
    end

endmodule

`default_nettype wire

// File: design/boardBuilder.sv
`default_nettype none

module boardBuilder (
    input  wire logic                                         clk,
    input  wire logic                                         rstN,
    input  wire logic                                         en,
    input  wire logic                                         load,
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationWhite,
    input  wire logic [chessPkg::pieceCount*chessPkg::locBits-1:0] locationBlack,
    input  wire logic [chessPkg::pieceCount-1:0]              aliveWhite,
    input  wire logic [chessPkg::pieceCount-1:0]              aliveBlack,
    output chessPkg::boardT                                   board
);
    import chessPkg::*;

    boardT nextBoard;

    always_comb begin
        nextBoard = '0;
        // Black first so a white piece on the same square overwrites it
        for (int i = 0; i < pieceCount; i++) begin
            if (aliveBlack[i]) begin
                nextBoard[entryRank(locationBlack, i)][entryFile(locationBlack, i)] =
                    '{occupied: 1'b1, white: 1'b0};
            end
        end
        for (int i = 0; i < pieceCount; i++) begin
            if (aliveWhite[i]) begin
                nextBoard[entryRank(locationWhite, i)][entryFile(locationWhite, i)] =
                    '{occupied: 1'b1, white: 1'b1};
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            board <= '0;
        end else if (en && load) begin
            board <= nextBoard;     // Held for the whole scan
        end
    end

endmodule

`default_nettype wire

// File: design/pieceQueryIf.sv
`default_nettype none

// Current piece out to the evaluators, results back in the same cycle
interface pieceQueryIf;
    import chessPkg::*;

    logic [coordBits-1:0] rank;
    logic [coordBits-1:0] file;
    pieceKindE            kind;
    logic                 ownWhite;
    rayCountsT            rays;
    logic [maskField-1:0] stepMask;

    modport requester (
        output rank, file, kind, ownWhite,
        input  rays, stepMask
    );

    modport slider (
        input  rank, file, ownWhite,
        output rays
    );

    modport stepper (
        input  rank, file, kind, ownWhite,
        output stepMask
    );

endinterface

`default_nettype wire

// File: design/chessPkg.sv
`default_nettype none

package chessPkg;

    // Board geometry
    localparam int boardSize   = 8;
    localparam int coordBits   = 3;
    localparam int locBits     = 6;     // Rank in the upper half, file in the lower
    localparam int pieceCount  = 16;
    localparam int firstPiece  = 0;     // King entry
    localparam int scanCount   = 8;     // Pawn entries 8 to 15 are skipped
    localparam int rayBits     = 3;
    localparam int moveSetBits = 96;
    localparam int dirCount    = 8;     // Rays per square and step targets per piece

    // Field widths of the summary
    localparam int rookField  = 12;
    localparam int queenField = 24;
    localparam int maskField  = 8;

    typedef struct packed {
        logic occupied;
        logic white;
    } squareT;

    typedef squareT [boardSize-1:0][boardSize-1:0] boardT;   // [rank][file]

    typedef logic [dirCount-1:0][rayBits-1:0] rayCountsT;     // Queen order, left on top

    typedef enum logic [2:0] {rook, knight, bishop, queen, king} pieceKindE;

    typedef enum logic {idle, scan} seqStateE;

    // Kind and field position by scan index
    localparam pieceKindE pieceKindOf [scanCount] =
        '{king, queen, bishop, bishop, knight, knight, rook, rook};
    localparam int fieldLsb [scanCount] = '{
        0,
        maskField,
        maskField + queenField,
        maskField + queenField + rookField,
        maskField + queenField + 2 * rookField,
        2 * maskField + queenField + 2 * rookField,
        3 * maskField + queenField + 2 * rookField,
        3 * maskField + queenField + 3 * rookField
    };

    // Ray steps, left right up down then the diagonals
    localparam int rayRankStep [dirCount] = '{0, 0, 1, -1, 1, 1, -1, -1};
    localparam int rayFileStep [dirCount] = '{-1, 1, 0, 0, -1, 1, -1, 1};

    // Jump and step tables, entry 0 lands in the top mask bit
    localparam int knightRankStep [dirCount] = '{2, 1, 2, 1, -2, -1, -2, -1};
    localparam int knightFileStep [dirCount] = '{-1, -2, 1, 2, -1, -2, 1, 2};
    localparam int kingRankStep   [dirCount] = '{1, 1, 1, 0, -1, -1, -1, 0};
    localparam int kingFileStep   [dirCount] = '{-1, 0, 1, 1, 1, 0, -1, -1};

    function automatic logic [coordBits-1:0] entryRank(
        input logic [pieceCount*locBits-1:0] vec,
        input int idx
    );
        return vec[idx * locBits + coordBits +: coordBits];
    endfunction

    function automatic logic [coordBits-1:0] entryFile(
        input logic [pieceCount*locBits-1:0] vec,
        input int idx
    );
        return vec[idx * locBits +: coordBits];
    endfunction

endpackage

`default_nettype wire
